//--- logic/queue_memory.sv
// shared word array split into per-queue regions, with head/tail/count and registered reads
`timescale 1ns/1ps
`include "sram_fifo_params.svh"

module queue_memory
    import sram_fifo_pkg::*;
(
    input  logic                     clk,
    input  logic                     memreset,
    queue_word_if.dst                wr_ch,
    input  logic                     rd_req_valid,
    input  queue_id_t                rd_req_qid,
    queue_word_if.src                rd_ret,
    output logic [`SF_NUM_QUEUES-1:0] region_full,
    output logic [`SF_NUM_QUEUES-1:0] region_empty
);

    localparam int slots = `SF_NUM_QUEUES * `SF_REGION_DEPTH;

    data_t                     mem_data [slots];
    logic                      mem_last [slots];
    region_ptr_t               head [`SF_NUM_QUEUES];
    region_ptr_t               tail [`SF_NUM_QUEUES];
    fill_count_t               count [`SF_NUM_QUEUES];
    slot_addr_t                wr_addr;
    slot_addr_t                rd_addr;
    logic [`SF_NUM_QUEUES-1:0] wr_hit;
    logic [`SF_NUM_QUEUES-1:0] rd_hit;

    // queue number picks the region, pointer the slot inside it
    assign wr_addr = {wr_ch.qid, tail[wr_ch.qid]};
    assign rd_addr = {rd_req_qid, head[rd_req_qid]};

    always_comb
    begin
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            wr_hit[i]       = wr_ch.valid && (wr_ch.qid == queue_id_t'(i));
            rd_hit[i]       = rd_req_valid && (rd_req_qid == queue_id_t'(i));
            region_full[i]  = (count[i] == fill_count_t'(`SF_REGION_DEPTH));
            region_empty[i] = (count[i] == '0);
        end
    end

    ////////////////////////////////////////
    // storage and read return
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wr_ch.valid)
        begin
            mem_data[wr_addr] <= wr_ch.data;
            mem_last[wr_addr] <= wr_ch.last;
        end
        // read data lands on rd_ret one cycle after the request
        if (rd_req_valid)
        begin
            rd_ret.data <= mem_data[rd_addr];
            rd_ret.last <= mem_last[rd_addr];
            rd_ret.qid  <= rd_req_qid;
        end
    end

    ////////////////////////////////////////
    // region bookkeeping
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            rd_ret.valid <= 1'b0;
            for (int i = 0; i < `SF_NUM_QUEUES; i++)
            begin
                head[i]  <= '0;
                tail[i]  <= '0;
                count[i] <= '0;
            end
        end
        else
        begin
            rd_ret.valid <= rd_req_valid;
            for (int i = 0; i < `SF_NUM_QUEUES; i++)
            begin
                if (wr_hit[i])
                    tail[i] <= tail[i] + 1'b1;
                if (rd_hit[i])
                    head[i] <= head[i] + 1'b1;
                // read and write on one queue cancel out
                if (wr_hit[i] && !rd_hit[i])
                    count[i] <= count[i] + 1'b1;
                else if (rd_hit[i] && !wr_hit[i])
                    count[i] <= count[i] - 1'b1;
            end
        end
    end

endmodule

//--- logic/queue_word_if.sv
// word channel carrying a tagged data word, used for memory writes and read returns
`timescale 1ns/1ps

interface queue_word_if
    import sram_fifo_pkg::*;
();

    // sender has checked for room before it drives valid
    logic      valid;
    queue_id_t qid;
    data_t     data;
    logic      last;

    modport src (
        output valid, qid, data, last
    );

    modport dst (
        input valid, qid, data, last
    );

endinterface

//--- logic/read_arbiter.sv
// credit-based round-robin read request issue toward the egress buffers
`timescale 1ns/1ps
`include "sram_fifo_params.svh"

module read_arbiter
    import sram_fifo_pkg::*;
(
    input  logic                     clk,
    input  logic                     memreset,
    input  logic [`SF_NUM_QUEUES-1:0] region_empty,
    input  logic [`SF_NUM_QUEUES-1:0] m_valid,
    input  logic [`SF_NUM_QUEUES-1:0] m_ready,
    output logic                     rd_req_valid,
    output queue_id_t                rd_req_qid
);

    credit_t                   credit [`SF_NUM_QUEUES];
    queue_id_t                 last_q;
    logic [`SF_NUM_QUEUES-1:0] eligible;
    logic [`SF_NUM_QUEUES-1:0] spend;
    logic [`SF_NUM_QUEUES-1:0] give_back;
    logic                      found;
    queue_id_t                 pick_q;

    // a queue needs stored words and a free egress place
    always_comb
    begin
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            eligible[i] = !region_empty[i] && (credit[i] != '0);
        end
    end

    always_comb
    begin : pick_next
        queue_id_t cand;
        found  = 1'b0;
        pick_q = last_q;
        for (int i = 1; i <= `SF_NUM_QUEUES; i++)
        begin
            cand = queue_id_t'((int'(last_q) + i) % `SF_NUM_QUEUES);
            if (!found && eligible[cand])
            begin
                found  = 1'b1;
                pick_q = cand;
            end
        end
    end

    assign rd_req_valid = found;
    assign rd_req_qid   = pick_q;

    always_comb
    begin
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            spend[i]     = found && (pick_q == queue_id_t'(i));
            give_back[i] = m_valid[i] && m_ready[i];
        end
    end

    ////////////////////////////////////////
    // credit counters
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            last_q <= '0;
            for (int i = 0; i < `SF_NUM_QUEUES; i++)
            begin
                credit[i] <= credit_t'(`SF_BUF_DEPTH);
            end
        end
        else
        begin
            if (found)
                last_q <= pick_q;
            for (int i = 0; i < `SF_NUM_QUEUES; i++)
            begin
                if (spend[i] && !give_back[i])
                    credit[i] <= credit[i] - 1'b1;
                else if (give_back[i] && !spend[i])
                    credit[i] <= credit[i] + 1'b1;
            end
        end
    end

endmodule

//--- logic/sram_fifo_params.svh
// size macros for the four-queue packet buffer
`ifndef SRAM_FIFO_PARAMS_SVH
`define SRAM_FIFO_PARAMS_SVH

// number of independent queues
`define SF_NUM_QUEUES 4

// stream word width in bits
`define SF_DATA_W 32

// memory words reserved per queue
`define SF_REGION_DEPTH 16

// ingress and egress buffer depth
`define SF_BUF_DEPTH 4

// max words written per grant
`define SF_BURST_LEN 4

`endif

//--- logic/sram_fifo_pkg.sv
// shared vector typedefs and the write arbiter state enum
`include "sram_fifo_params.svh"

package sram_fifo_pkg;

    // stream payload word
    typedef logic [`SF_DATA_W-1:0] data_t;

    // queue number
    typedef logic [1:0] queue_id_t;

    // head or tail position inside one region
    typedef logic [3:0] region_ptr_t;

    // {queue, position} address into the shared array
    typedef logic [5:0] slot_addr_t;

    // words held in one region, 0 to 16
    typedef logic [4:0] fill_count_t;

    // free egress places for one queue, 0 to 4
    typedef logic [2:0] credit_t;

    typedef enum logic {
        arb_idle,
        arb_burst
    } arb_state_t;

endpackage

//--- logic/sram_fifo_top.sv
// top level with ingress/egress buffers, write and read arbiters and the shared memory
`timescale 1ns/1ps
`include "sram_fifo_params.svh"

module sram_fifo_top
    import sram_fifo_pkg::*;
(
    input  logic                     clk,
    input  logic                     memreset,

    // input streams
    input  logic [`SF_NUM_QUEUES-1:0] s_valid,
    output logic [`SF_NUM_QUEUES-1:0] s_ready,
    input  logic [`SF_NUM_QUEUES-1:0] s_last,
    input  data_t                    s_data [`SF_NUM_QUEUES],

    // output streams
    output logic [`SF_NUM_QUEUES-1:0] m_valid,
    input  logic [`SF_NUM_QUEUES-1:0] m_ready,
    output logic [`SF_NUM_QUEUES-1:0] m_last,
    output data_t                    m_data [`SF_NUM_QUEUES]
);

    logic [`SF_NUM_QUEUES-1:0] ing_valid;
    logic [`SF_NUM_QUEUES-1:0] ing_last;
    data_t                     ing_data [`SF_NUM_QUEUES];
    logic [`SF_NUM_QUEUES-1:0] grant_pop;
    logic [`SF_NUM_QUEUES-1:0] region_full;
    logic [`SF_NUM_QUEUES-1:0] region_empty;
    logic                      rd_req_valid;
    queue_id_t                 rd_req_qid;
    logic [`SF_NUM_QUEUES-1:0] egr_push;

    queue_word_if wr_ch ();
    queue_word_if rd_ret ();

    ////////////////////////////////////////
    // ingress side
    ////////////////////////////////////////

    for (genvar i = 0; i < `SF_NUM_QUEUES; i++)
    begin : g_ingress
        word_buffer #(.depth(`SF_BUF_DEPTH)) u_ing_buf (
            .clk       (clk),
            .memreset  (memreset),
            .in_valid  (s_valid[i]),
            .in_ready  (s_ready[i]),
            .in_data   (s_data[i]),
            .in_last   (s_last[i]),
            .out_valid (ing_valid[i]),
            .out_ready (grant_pop[i]),
            .out_data  (ing_data[i]),
            .out_last  (ing_last[i])
        );
    end

    write_arbiter u_write_arb (
        .clk         (clk),
        .memreset    (memreset),
        .req_valid   (ing_valid),
        .req_last    (ing_last),
        .req_data    (ing_data),
        .grant_pop   (grant_pop),
        .region_full (region_full),
        .wr_ch       (wr_ch)
    );

    queue_memory u_queue_mem (
        .clk          (clk),
        .memreset     (memreset),
        .wr_ch        (wr_ch),
        .rd_req_valid (rd_req_valid),
        .rd_req_qid   (rd_req_qid),
        .rd_ret       (rd_ret),
        .region_full  (region_full),
        .region_empty (region_empty)
    );

    read_arbiter u_read_arb (
        .clk          (clk),
        .memreset     (memreset),
        .region_empty (region_empty),
        .m_valid      (m_valid),
        .m_ready      (m_ready),
        .rd_req_valid (rd_req_valid),
        .rd_req_qid   (rd_req_qid)
    );

    ////////////////////////////////////////
    // egress side
    ////////////////////////////////////////

    // steer each read return to the buffer of its queue
    always_comb
    begin
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            egr_push[i] = rd_ret.valid && (rd_ret.qid == queue_id_t'(i));
        end
    end

    for (genvar i = 0; i < `SF_NUM_QUEUES; i++)
    begin : g_egress
        // every read was issued against a credit so the buffer always has room
        word_buffer #(.depth(`SF_BUF_DEPTH)) u_egr_buf (
            .clk       (clk),
            .memreset  (memreset),
            .in_valid  (egr_push[i]),
            .in_ready  (),
            .in_data   (rd_ret.data),
            .in_last   (rd_ret.last),
            .out_valid (m_valid[i]),
            .out_ready (m_ready[i]),
            .out_data  (m_data[i]),
            .out_last  (m_last[i])
        );
    end

endmodule

//--- logic/word_buffer.sv
// small circular word fifo with valid/ready on both sides
`timescale 1ns/1ps
`include "sram_fifo_params.svh"

module word_buffer
    import sram_fifo_pkg::*;
#(
    parameter int depth = `SF_BUF_DEPTH
)
(
    input  logic  clk,
    input  logic  memreset,
    input  logic  in_valid,
    output logic  in_ready,
    input  data_t in_data,
    input  logic  in_last,
    output logic  out_valid,
    input  logic  out_ready,
    output data_t out_data,
    output logic  out_last
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    data_t            mem_data [depth];
    logic             mem_last [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    // wrap for depths that are not a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != cnt_w'(depth));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem_data[rd_ptr];
    assign out_last  = mem_last[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem_data[wr_ptr] <= in_data;
            mem_last[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            // simultaneous push and pop leaves count alone
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

//--- logic/write_arbiter.sv
// round-robin burst arbiter moving ingress words onto the memory write channel
`timescale 1ns/1ps
`include "sram_fifo_params.svh"

module write_arbiter
    import sram_fifo_pkg::*;
(
    input  logic                     clk,
    input  logic                     memreset,
    input  logic [`SF_NUM_QUEUES-1:0] req_valid,
    input  logic [`SF_NUM_QUEUES-1:0] req_last,
    input  data_t                    req_data [`SF_NUM_QUEUES],
    output logic [`SF_NUM_QUEUES-1:0] grant_pop,
    input  logic [`SF_NUM_QUEUES-1:0] region_full,
    queue_word_if.src                wr_ch
);

    localparam int burst_w = $clog2(`SF_BURST_LEN + 1);

    arb_state_t         state;
    queue_id_t          cur_q;
    logic [burst_w-1:0] burst_cnt;
    logic               pick_found;
    queue_id_t          pick_q;
    logic               pop;
    queue_id_t          pop_q;
    logic               burst_end;

    ////////////////////////////////////////
    // queue selection
    ////////////////////////////////////////

    // search starts one past the last granted queue
    always_comb
    begin : pick_next
        queue_id_t cand;
        pick_found = 1'b0;
        pick_q     = cur_q;
        for (int i = 1; i <= `SF_NUM_QUEUES; i++)
        begin
            cand = queue_id_t'((int'(cur_q) + i) % `SF_NUM_QUEUES);
            if (!pick_found && req_valid[cand] && !region_full[cand])
            begin
                pick_found = 1'b1;
                pick_q     = cand;
            end
        end
    end

    // idle grants the picked queue at once, burst sticks with cur_q
    always_comb
    begin
        if (state == arb_burst)
        begin
            pop_q = cur_q;
            pop   = req_valid[cur_q] && !region_full[cur_q];
        end
        else
        begin
            pop_q = pick_q;
            pop   = pick_found;
        end
    end

    assign burst_end = req_last[pop_q] || (burst_cnt == burst_w'(`SF_BURST_LEN - 1));

    ////////////////////////////////////////
    // burst tracking
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            state     <= arb_idle;
            cur_q     <= '0;
            burst_cnt <= '0;
        end
        else if (pop)
        begin
            cur_q <= pop_q;
            if (burst_end)
            begin
                state     <= arb_idle;
                burst_cnt <= '0;
            end
            else
            begin
                state     <= arb_burst;
                burst_cnt <= burst_cnt + 1'b1;
            end
        end
        else if (state == arb_burst)
        begin
            // ingress ran dry or region filled
            state     <= arb_idle;
            burst_cnt <= '0;
        end
    end

    always_comb
    begin
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            grant_pop[i] = pop && (pop_q == queue_id_t'(i));
        end
    end

    // popped word goes straight to memory
    assign wr_ch.valid = pop;
    assign wr_ch.qid   = pop_q;
    assign wr_ch.data  = req_data[pop_q];
    assign wr_ch.last  = req_last[pop_q];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f vlog.f --top-module tb_sram_fifo -Mdir obj_dir \
    > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_sram_fifo > sim.log 2>&1 || echo "simulator returned a nonzero status"

grep -q "^test passed$" sim.log && echo "PASS, see sim.log" && exit 0 \
    || { echo "FAIL, see sim.log"; exit 1; }

//--- testbench/tb_checker.sv
// output checker with per-queue reference queues, reset and fill checks, and the error summary
`timescale 1ns/1ps
`include "sram_fifo_params.svh"

module tb_checker
    import sram_fifo_pkg::*;
#(
    // ingress + region + egress words that a blocked queue holds
    parameter int fill_expect = 2 * `SF_BUF_DEPTH + `SF_REGION_DEPTH
)
(
    input  logic                      clk,
    input  logic                      memreset,
    input  logic [`SF_NUM_QUEUES-1:0] s_valid,
    input  logic [`SF_NUM_QUEUES-1:0] s_ready,
    input  logic [`SF_NUM_QUEUES-1:0] s_last,
    input  data_t                     s_data [`SF_NUM_QUEUES],
    input  logic [`SF_NUM_QUEUES-1:0] m_valid,
    input  logic [`SF_NUM_QUEUES-1:0] m_ready,
    input  logic [`SF_NUM_QUEUES-1:0] m_last,
    input  data_t                     m_data [`SF_NUM_QUEUES],
    input  logic [`SF_NUM_QUEUES-1:0] check_fill,
    input  logic                      run_done,
    output int                        pending [`SF_NUM_QUEUES],
    output int                        error_total
);

    // each entry is {last, data}
    logic [`SF_DATA_W:0] ref_q [`SF_NUM_QUEUES][$];

    int   data_errs;
    int   last_errs;
    int   extra_words;
    int   lost_words;
    int   state_errs;
    logic in_reset = 1'b0;
    logic reported = 1'b0;

    always @(posedge clk)
    begin : compare
        logic [`SF_DATA_W:0] exp_word;
        if (memreset)
        begin
            in_reset = 1'b1;
        end
        else
        begin
            ////////////////////////////////////////
            // first edge after reset
            ////////////////////////////////////////
            if (in_reset)
            begin
                if (m_valid !== '0)
                begin
                    $display("Error at %0t: m_valid is %b after reset, expected all low",
                             $time, m_valid);
                    state_errs++;
                end
                if (s_ready !== '1)
                begin
                    $display("Error at %0t: s_ready is %b after reset, expected all high",
                             $time, s_ready);
                    state_errs++;
                end
                in_reset = 1'b0;
            end

            ////////////////////////////////////////
            // per-queue scoreboard
            ////////////////////////////////////////
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                if (s_valid[q] && s_ready[q])
                    ref_q[q].push_back({s_last[q], s_data[q]});
                if (m_valid[q] && m_ready[q])
                begin
                    if (ref_q[q].size() == 0)
                    begin
                        $display("queue %0d put out word %h at %0t with no input word pending",
                                 q, m_data[q], $time);
                        extra_words++;
                    end
                    else
                    begin
                        exp_word = ref_q[q].pop_front();
                        if (m_data[q] !== exp_word[`SF_DATA_W-1:0])
                        begin
                            $display("Error at %0t: queue %0d data %h, expected %h",
                                     $time, q, m_data[q], exp_word[`SF_DATA_W-1:0]);
                            data_errs++;
                        end
                        if (m_last[q] !== exp_word[`SF_DATA_W])
                        begin
                            $display("Error at %0t: queue %0d last %b, expected %b",
                                     $time, q, m_last[q], exp_word[`SF_DATA_W]);
                            last_errs++;
                        end
                    end
                end
                // blocked queue must sit at full capacity
                if (check_fill[q])
                begin
                    if (ref_q[q].size() != fill_expect)
                    begin
                        $display("Error at %0t: queue %0d holds %0d words, expected %0d",
                                 $time, q, ref_q[q].size(), fill_expect);
                        state_errs++;
                    end
                    if (s_ready[q])
                    begin
                        $display("Error at %0t: queue %0d s_ready high while full", $time, q);
                        state_errs++;
                    end
                end
                pending[q] = ref_q[q].size();
            end

            if (run_done && !reported)
            begin
                for (int q = 0; q < `SF_NUM_QUEUES; q++)
                begin
                    if (ref_q[q].size() != 0)
                    begin
                        $display("queue %0d ended with %0d accepted words that never came out",
                                 q, ref_q[q].size());
                        lost_words += ref_q[q].size();
                    end
                end
                error_total = data_errs + last_errs + extra_words + lost_words + state_errs;
                $display("checker summary: %0d data, %0d last, %0d unexpected, %0d lost, %0d state",
                         data_errs, last_errs, extra_words, lost_words, state_errs);
                reported = 1'b1;
            end
        end
    end

endmodule

//--- testbench/tb_clock_gen.sv
// free-running testbench clock source
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int half_period = 20
)
(
    output logic clk
);

    // 40 ns period with the default half period
    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

//--- testbench/tb_sram_fifo.sv
// testbench top with reset, seeded random streams, output ready patterns and the run timeout
`timescale 1ns/1ps
`include "sram_fifo_params.svh"

module tb_sram_fifo
    import sram_fifo_pkg::*;
();

    localparam int nq = `SF_NUM_QUEUES;
    localparam int words_per_phase = 300;
    // three phases at up to 8 cycles per word plus slack
    localparam int timeout_cycles = 3 * words_per_phase * 8 + 800;
    // queue held back in the isolation phase
    localparam int blocked_q = 2;
    localparam logic [nq-1:0] blocked_mask = nq'(1) << blocked_q;
    localparam int blocked_words = 40;

    logic          clk;
    logic          memreset;
    logic [nq-1:0] s_valid;
    logic [nq-1:0] s_ready;
    logic [nq-1:0] s_last;
    data_t         s_data [nq];
    logic [nq-1:0] m_valid;
    logic [nq-1:0] m_ready;
    logic [nq-1:0] m_last;
    data_t         m_data [nq];
    logic [nq-1:0] check_fill;
    logic          run_done;
    int            pending [nq];
    int            error_total;

    int            seed;
    int            sent [nq];
    int            target [nq];
    int            pkt_left [nq];
    logic [nq-1:0] fire;
    int            stall_run;
    int            cycle_cnt;

    tb_clock_gen #(.half_period(20)) clk_gen (.clk(clk));

    sram_fifo_top uut (
        .clk      (clk),
        .memreset (memreset),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .s_last   (s_last),
        .s_data   (s_data),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .m_last   (m_last),
        .m_data   (m_data)
    );

    tb_checker chk (
        .clk         (clk),
        .memreset    (memreset),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .s_last      (s_last),
        .s_data      (s_data),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_last      (m_last),
        .m_data      (m_data),
        .check_fill  (check_fill),
        .run_done    (run_done),
        .pending     (pending),
        .error_total (error_total)
    );

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // new packet length 1 to 6 when the previous one closed
    function automatic void present_word(input int q);
        int r;
        if (pkt_left[q] == 0)
        begin
            r = $random(seed);
            pkt_left[q] = int'($unsigned(r) % 32'd6) + 1;
        end
        s_data[q]  = $random(seed);
        s_last[q]  = (pkt_left[q] == 1);
        s_valid[q] = 1'b1;
        pkt_left[q]--;
    endfunction

    function automatic bit traffic_done();
        bit done;
        done = (s_valid == '0);
        for (int q = 0; q < nq; q++)
        begin
            if (sent[q] != target[q] || pending[q] != 0)
                done = 1'b0;
        end
        return done;
    endfunction

    function automatic bit others_sent();
        bit done;
        done = 1'b1;
        for (int q = 0; q < nq; q++)
        begin
            if (q != blocked_q && sent[q] != target[q])
                done = 1'b0;
        end
        return done;
    endfunction

    // note the handshakes of one edge and drive inputs 2 ns after it
    task automatic step(input logic [nq-1:0] greedy, input bit rand_ready,
                        input logic [nq-1:0] ready_val);
        int r;
        @(negedge clk);
        fire = s_valid & s_ready;
        @(posedge clk);
        #2;
        for (int q = 0; q < nq; q++)
        begin
            if (fire[q])
            begin
                sent[q]++;
                s_valid[q] = 1'b0;
            end
            if (!s_valid[q] && sent[q] < target[q])
            begin
                r = $random(seed);
                // offer a word on three cycles out of four
                if (greedy[q] || r[1:0] != 2'b00)
                    present_word(q);
            end
        end
        if (rand_ready)
        begin
            r = $random(seed);
            m_ready = r[nq-1:0];
        end
        else
            m_ready = ready_val;
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial
    begin
        seed       = 32'hb0bb709b;
        memreset   = 1'b1;
        s_valid    = '0;
        s_last     = '0;
        m_ready    = '0;
        check_fill = '0;
        run_done   = 1'b0;
        fire       = '0;
        stall_run  = 0;
        for (int q = 0; q < nq; q++)
        begin
            s_data[q]   = '0;
            sent[q]     = 0;
            target[q]   = 0;
            pkt_left[q] = 0;
        end
        repeat (2) @(posedge clk);
        #2;
        memreset = 1'b0;
        m_ready  = '1;

        // all outputs ready
        for (int q = 0; q < nq; q++)
            target[q] += words_per_phase;
        while (!traffic_done())
            step('0, 1'b0, '1);

        // one output held while its queue fills and the rest keep moving
        for (int q = 0; q < nq; q++)
            target[q] += (q == blocked_q) ? blocked_words : words_per_phase;
        m_ready = ~blocked_mask;
        while (stall_run < blocked_words || !others_sent())
        begin
            step(blocked_mask, 1'b0, ~blocked_mask);
            if (s_valid[blocked_q] && !fire[blocked_q])
                stall_run++;
            else
                stall_run = 0;
        end
        check_fill = blocked_mask;
        step(blocked_mask, 1'b0, '1);
        check_fill = '0;
        while (!traffic_done())
            step(blocked_mask, 1'b0, '1);

        // random output back-pressure everywhere
        for (int q = 0; q < nq; q++)
            target[q] += words_per_phase;
        while (!traffic_done())
            step('0, 1'b1, '1);

        run_done = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (error_total == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // run limit
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("test failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/sram_fifo_pkg.sv
logic/queue_word_if.sv
logic/word_buffer.sv
logic/write_arbiter.sv
logic/queue_memory.sv
logic/read_arbiter.sv
logic/sram_fifo_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_sram_fifo.sv
